// ==== all.f ====
hdl/or1k_isa_pkg.sv
hdl/dx_pipe_pkg.sv
hdl/dx_hazard_unit.sv
hdl/dx_branch_resolver.sv
hdl/dx_stage_regs.sv
hdl/dx_top.sv
verification/dx_model.sv
verification/dx_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary -f all.f --top-module dx_tb -o dx_sim
out=$(./obj_dir/dx_sim)
echo "$out"
if echo "$out" | grep -qx "STATUS: PASS"; then
   exit 0
fi
exit 1

// ==== verification/dx_tb.sv ====
/*
 * Testbench for the decode to execute stage: random and directed
 * stimulus checked against the reference model
 */

module dx_tb;

   localparam int random_cycles  = 2000;
   localparam int timeout_cycles = random_cycles + 1000;

   logic clk = 1'b0;
   logic rst = 1'b1;
   dx_pipe_pkg::dx_decode_s  decode;
   dx_pipe_pkg::dx_ctrl_s    ctrl;
   or1k_isa_pkg::word_t      execute_rfb;
   logic                     predicted_flag;
   logic                     padv;
   logic                     flush;
   dx_pipe_pkg::dx_execute_s execute, exp_execute;
   logic branch, bubble, valid, exp_branch, exp_bubble, exp_valid;
   logic data_loaded, pred_loaded;
   or1k_isa_pkg::word_t target, exp_target;
   int exec_errors = 0;
   int word_errors = 0;
   int bit_errors  = 0;
   int cycles      = 0;

   dx_top i_dx_top (
      .clk(clk), .rst(rst), .decode_i(decode), .ctrl_i(ctrl), .execute_rfb_i(execute_rfb),
      .predicted_flag_i(predicted_flag), .padv_i(padv), .pipeline_flush_i(flush),
      .execute_o(execute), .decode_branch_o(branch), .decode_branch_target_o(target),
      .decode_bubble_o(bubble), .decode_valid_o(valid)
   );

   dx_model model (
      .clk(clk), .rst(rst), .decode_i(decode), .ctrl_i(ctrl), .execute_rfb_i(execute_rfb),
      .predicted_flag_i(predicted_flag), .padv_i(padv), .pipeline_flush_i(flush),
      .exp_execute_o(exp_execute), .exp_branch_o(exp_branch), .exp_target_o(exp_target),
      .exp_bubble_o(exp_bubble), .exp_valid_o(exp_valid),
      .data_loaded_o(data_loaded), .pred_loaded_o(pred_loaded)
   );

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= timeout_cycles) begin
         $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   // unreset payload is only meaningful once loaded
   function automatic dx_pipe_pkg::dx_execute_s mask_unloaded(
      input dx_pipe_pkg::dx_execute_s e);
      if (!data_loaded) begin
         e.pc = '0;
         e.imm = '0;
         e.immediate = '0;
         e.immediate_sel = 1'b0;
         e.rfd_adr = '0;
         e.jal_result = '0;
      end
      if (!pred_loaded) begin
         e.mispredict_target = '0;
         e.predicted_flag = 1'b0;
      end
      return e;
   endfunction

   task automatic compare_execute(input dx_pipe_pkg::dx_execute_s got,
                                  input dx_pipe_pkg::dx_execute_s exp);
      got = mask_unloaded(got);
      exp = mask_unloaded(exp);
      if (got !== exp) begin
         exec_errors++;
         $display("Mismatch at %0t: execute_o got %p expected %p", $time, got, exp);
      end
   endtask

   task automatic compare_word(input string name, input or1k_isa_pkg::word_t got,
                               input or1k_isa_pkg::word_t exp);
      if (got !== exp) begin
         word_errors++;
         $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic compare_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         bit_errors++;
         $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   function automatic dx_pipe_pkg::dx_decode_s random_decode();
      dx_pipe_pkg::dx_decode_s d;
      d.pc = or1k_isa_pkg::word_t'($urandom) & ~32'h3;
      d.ops = dx_pipe_pkg::dx_ops_s'(18'($urandom & $urandom & $urandom));
      d.opc_insn = or1k_isa_pkg::opcode_t'($urandom);
      d.imm = or1k_isa_pkg::insn_imm_u'(26'($urandom));
      d.immediate = $urandom;
      d.immediate_sel = 1'($urandom);
      // small register range so hazards are frequent
      d.rfd_adr = or1k_isa_pkg::rf_addr_t'($urandom_range(0, 3));
      d.rfa_adr = or1k_isa_pkg::rf_addr_t'($urandom_range(0, 3));
      d.rfb_adr = or1k_isa_pkg::rf_addr_t'($urandom_range(0, 3));
      d.rf_wb = 1'($urandom);
      d.rfb = $urandom;
      d.except = dx_pipe_pkg::dx_except_s'({4'($urandom & $urandom), 1'b0});
      return d;
   endfunction

   // drive on the falling edge, check just before the rising edge
   task automatic step(input dx_pipe_pkg::dx_decode_s d, input logic adv, input logic fl);
      @(negedge clk);
      decode = d;
      ctrl = dx_pipe_pkg::dx_ctrl_s'({3'($urandom & $urandom),
                                      or1k_isa_pkg::rf_addr_t'($urandom_range(0, 3))});
      execute_rfb = $urandom;
      predicted_flag = 1'($urandom);
      padv = adv;
      flush = fl;
      #4;
      compare_execute(execute, exp_execute);
      compare_word("decode_branch_target_o", target, exp_target);
      compare_bit("decode_branch_o", branch, exp_branch);
      compare_bit("decode_bubble_o", bubble, exp_bubble);
      compare_bit("decode_valid_o", valid, exp_valid);
   endtask

   initial begin
      dx_pipe_pkg::dx_decode_s d;
      void'($urandom(32'h134f));
      decode = '0;
      decode.ops.brcond = 1'b1;
      ctrl = '0;
      execute_rfb = '0;
      predicted_flag = 1'b0;
      padv = 1'b1;
      flush = 1'b0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      // load in execute followed by a dependent read
      d = random_decode();
      d.ops = '0;
      d.ops.lsu_load = 1'b1;
      d.rfd_adr = 5'd2;
      step(d, 1'b1, 1'b0);
      d = random_decode();
      d.ops.rfe = 1'b0;
      d.rfa_adr = 5'd2;
      step(d, 1'b1, 1'b0);
      // flush with exception bits pending
      d = random_decode();
      d.except.illegal = 1'b1;
      step(d, 1'b1, 1'b1);
      // rfe bubbles but still travels
      d = random_decode();
      d.ops.rfe = 1'b1;
      step(d, 1'b1, 1'b0);
      step(random_decode(), 1'b0, 1'b0);
      repeat (random_cycles) begin
         step(random_decode(), $urandom_range(0, 9) < 8, $urandom_range(0, 9) == 0);
      end
      $display("errors: execute %0d, word %0d, bit %0d", exec_errors, word_errors, bit_errors);
      if (exec_errors + word_errors + bit_errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

// ==== verification/dx_model.sv ====
/*
 * Reference model of the decode to execute stage: hazard, branch
 * and execute register behavior, with load tracking of unreset data
 */

module dx_model (
   input  logic                     clk,
   input  logic                     rst,
   input  dx_pipe_pkg::dx_decode_s  decode_i,
   input  dx_pipe_pkg::dx_ctrl_s    ctrl_i,
   input  or1k_isa_pkg::word_t      execute_rfb_i,
   input  logic                     predicted_flag_i,
   input  logic                     padv_i,
   input  logic                     pipeline_flush_i,
   output dx_pipe_pkg::dx_execute_s exp_execute_o,
   output logic                     exp_branch_o,
   output or1k_isa_pkg::word_t      exp_target_o,
   output logic                     exp_bubble_o,
   output logic                     exp_valid_o,
   output logic                     data_loaded_o,
   output logic                     pred_loaded_o
);

   dx_pipe_pkg::dx_execute_s st;
   dx_pipe_pkg::dx_execute_s nxt;
   logic                     interlock;
   logic                     imm_taken;
   logic                     reg_taken;
   or1k_isa_pkg::word_t      imm_target;
   or1k_isa_pkg::word_t      reg_target;
   or1k_isa_pkg::word_t      link;

   // ops whose result is late for bypassing
   function automatic logic late_op(input logic load, input logic mfspr, input logic mul);
      return load | mfspr | mul;
   endfunction

   function automatic or1k_isa_pkg::word_t byte_offset(input or1k_isa_pkg::insn_imm_u imm);
      or1k_isa_pkg::word_t words;
      words = or1k_isa_pkg::word_t'($signed(imm.jump_off));
      return words * or1k_isa_pkg::insn_step;
   endfunction

   always_comb begin
      interlock = late_op(ctrl_i.op_lsu_load, ctrl_i.op_mfspr, ctrl_i.op_mul) &
                  (decode_i.rfb_adr == ctrl_i.rfd_adr);
      exp_bubble_o = padv_i & (decode_i.ops.rfe |
         (late_op(st.ops.lsu_load, st.ops.mfspr, st.ops.mul) &
          (decode_i.rfa_adr == st.rfd_adr || decode_i.rfb_adr == st.rfd_adr)) |
         (ctrl_i.op_mul &
          (decode_i.rfa_adr == ctrl_i.rfd_adr || decode_i.rfb_adr == ctrl_i.rfd_adr)) |
         (decode_i.ops.jr & (interlock | decode_i.rfb_adr == st.rfd_adr)));
      imm_taken = decode_i.ops.jbr & ((decode_i.opc_insn[2:1] == 2'b00) |
                                      (decode_i.opc_insn[2] == predicted_flag_i));
      reg_taken = decode_i.ops.jr & ~interlock;
      imm_target = decode_i.pc + byte_offset(decode_i.imm);
      reg_target = (st.bubble | st.ops.jr) ? execute_rfb_i : decode_i.rfb;
      exp_target_o = imm_taken ? imm_target : reg_target;
      exp_branch_o = (imm_taken | reg_taken) & ~pipeline_flush_i & ~exp_bubble_o;
      link = decode_i.pc + 32'd8;
   end

   always @(posedge clk) begin
      nxt = st;
      if (padv_i) begin
         nxt.pc = decode_i.pc;
         nxt.imm = decode_i.imm;
         nxt.immediate = decode_i.immediate;
         nxt.immediate_sel = decode_i.immediate_sel;
         nxt.rfd_adr = decode_i.rfd_adr;
         nxt.jal_result = link;
         nxt.except = decode_i.except;
         nxt.except.ibus_align = exp_branch_o & (exp_target_o[1:0] != 2'b00);
         nxt.ops = exp_bubble_o ? '0 : decode_i.ops;
         nxt.ops.rfe = decode_i.ops.rfe;
         nxt.rf_wb = decode_i.rf_wb & ~exp_bubble_o;
         nxt.opc_insn = exp_bubble_o ? or1k_isa_pkg::opcode_nop : decode_i.opc_insn;
         nxt.bubble = exp_bubble_o;
         data_loaded_o <= 1'b1;
         if (decode_i.ops.brcond) begin
            nxt.predicted_flag = predicted_flag_i;
            nxt.mispredict_target =
               ((decode_i.ops.bf & ~predicted_flag_i) | (decode_i.ops.bnf & predicted_flag_i)) ?
               imm_target : link;
            pred_loaded_o <= 1'b1;
         end
      end
      if (rst || pipeline_flush_i) begin
         nxt.ops = '0;
         nxt.rf_wb = 1'b0;
         nxt.bubble = 1'b0;
         nxt.opc_insn = or1k_isa_pkg::opcode_nop;
      end
      if (rst) begin
         nxt.except = '0;
      end
      st <= nxt;
      exp_valid_o <= ~rst & padv_i;
   end

   initial begin
      data_loaded_o = 1'b0;
      pred_loaded_o = 1'b0;
   end

   assign exp_execute_o = st;

endmodule

// ==== hdl/dx_top.sv ====
/*
 * Decode to execute stage top level: hazard unit, branch
 * resolver and execute stage registers
 */

module dx_top (
   input  logic                    clk,
   input  logic                    rst,
   input  dx_pipe_pkg::dx_decode_s  decode_i,
   input  dx_pipe_pkg::dx_ctrl_s    ctrl_i,
   input  or1k_isa_pkg::word_t     execute_rfb_i,
   input  logic                    predicted_flag_i,
   input  logic                    padv_i,
   input  logic                    pipeline_flush_i,
   output dx_pipe_pkg::dx_execute_s execute_o,
   output logic                    decode_branch_o,
   output or1k_isa_pkg::word_t     decode_branch_target_o,
   output logic                    decode_bubble_o,
   output logic                    decode_valid_o
);

   logic                ctrl_interlock;
   logic                ibus_align;
   or1k_isa_pkg::word_t jal_result;
   or1k_isa_pkg::word_t mispredict_target;

   // execute_o feeds back for the execute destination and bubble
   dx_hazard_unit i_dx_hazard_unit (
      .padv_i           (padv_i),
      .decode_i         (decode_i),
      .ctrl_i           (ctrl_i),
      .execute_i        (execute_o),
      .decode_bubble_o  (decode_bubble_o),
      .ctrl_interlock_o (ctrl_interlock)
   );

   dx_branch_resolver i_dx_branch_resolver (
      .decode_i               (decode_i),
      .execute_i              (execute_o),
      .execute_rfb_i          (execute_rfb_i),
      .predicted_flag_i       (predicted_flag_i),
      .pipeline_flush_i       (pipeline_flush_i),
      .decode_bubble_i        (decode_bubble_o),
      .ctrl_interlock_i       (ctrl_interlock),
      .decode_branch_o        (decode_branch_o),
      .decode_branch_target_o (decode_branch_target_o),
      .ibus_align_o           (ibus_align),
      .jal_result_o           (jal_result),
      .mispredict_target_o    (mispredict_target)
   );

   dx_stage_regs i_dx_stage_regs (
      .clk                 (clk),
      .rst                 (rst),
      .padv_i              (padv_i),
      .pipeline_flush_i    (pipeline_flush_i),
      .decode_i            (decode_i),
      .decode_bubble_i     (decode_bubble_o),
      .ibus_align_i        (ibus_align),
      .predicted_flag_i    (predicted_flag_i),
      .jal_result_i        (jal_result),
      .mispredict_target_i (mispredict_target),
      .execute_o           (execute_o),
      .decode_valid_o      (decode_valid_o)
   );

endmodule

// ==== hdl/dx_stage_regs.sv ====
/*
 * Execute side pipeline registers: control state with reset, flush
 * and bubble squashing, exception bits, unreset payload, branch
 * prediction fields and the decode valid flag
 */

module dx_stage_regs (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    padv_i,
   input  logic                    pipeline_flush_i,
   input  dx_pipe_pkg::dx_decode_s  decode_i,
   input  logic                    decode_bubble_i,
   input  logic                    ibus_align_i,
   input  logic                    predicted_flag_i,
   input  or1k_isa_pkg::word_t     jal_result_i,
   input  or1k_isa_pkg::word_t     mispredict_target_i,
   output dx_pipe_pkg::dx_execute_s execute_o,
   output logic                    decode_valid_o
);

   // control state
   dx_pipe_pkg::dx_ops_s    ops_q;
   dx_pipe_pkg::dx_ops_s    ops_next;
   or1k_isa_pkg::opcode_t   opc_insn_q;
   logic                    rf_wb_q;
   logic                    bubble_q;
   dx_pipe_pkg::dx_except_s except_q;
   dx_pipe_pkg::dx_except_s except_next;

   // payload
   or1k_isa_pkg::word_t     pc_q;
   or1k_isa_pkg::insn_imm_u imm_q;
   or1k_isa_pkg::word_t     immediate_q;
   logic                    immediate_sel_q;
   or1k_isa_pkg::rf_addr_t  rfd_adr_q;
   or1k_isa_pkg::word_t     jal_result_q;
   or1k_isa_pkg::word_t     mispredict_target_q;
   logic                    predicted_flag_q;

   // a bubble squashes every op except rfe, which has to reach
   // control to take the return; its own flush clears it later
   always_comb begin
      ops_next = decode_i.ops;
      if (decode_bubble_i) begin
         ops_next     = '0;
         ops_next.rfe = decode_i.ops.rfe;
      end
   end

   // alignment fault is found here, not in fetch
   always_comb begin
      except_next            = decode_i.except;
      except_next.ibus_align = ibus_align_i;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         ops_q      <= '0;
         opc_insn_q <= or1k_isa_pkg::opcode_nop;
         rf_wb_q    <= 1'b0;
         bubble_q   <= 1'b0;
      end else if (pipeline_flush_i) begin
         ops_q      <= '0;
         opc_insn_q <= or1k_isa_pkg::opcode_nop;
         rf_wb_q    <= 1'b0;
         bubble_q   <= 1'b0;
      end else if (padv_i) begin
         ops_q    <= ops_next;
         rf_wb_q  <= decode_i.rf_wb & ~decode_bubble_i;
         bubble_q <= decode_bubble_i;
         if (decode_bubble_i) begin
            opc_insn_q <= or1k_isa_pkg::opcode_nop;
         end else begin
            opc_insn_q <= decode_i.opc_insn;
         end
      end
   end

   // exceptions are not flushed, only loaded on advance
   always_ff @(posedge clk) begin
      if (rst) begin
         except_q <= '0;
      end else if (padv_i) begin
         except_q <= except_next;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         decode_valid_o <= 1'b0;
      end else begin
         decode_valid_o <= padv_i;
      end
   end

   always_ff @(posedge clk) begin
      if (padv_i) begin
         pc_q            <= decode_i.pc;
         imm_q           <= decode_i.imm;
         immediate_q     <= decode_i.immediate;
         immediate_sel_q <= decode_i.immediate_sel;
         rfd_adr_q       <= decode_i.rfd_adr;
         jal_result_q    <= jal_result_i;
      end
   end

   // prediction info only matters for conditional branches
   always_ff @(posedge clk) begin
      if (padv_i & decode_i.ops.brcond) begin
         mispredict_target_q <= mispredict_target_i;
         predicted_flag_q    <= predicted_flag_i;
      end
   end

   assign execute_o = '{
      pc:                pc_q,
      ops:               ops_q,
      opc_insn:          opc_insn_q,
      imm:               imm_q,
      immediate:         immediate_q,
      immediate_sel:     immediate_sel_q,
      rfd_adr:           rfd_adr_q,
      rf_wb:             rf_wb_q,
      jal_result:        jal_result_q,
      mispredict_target: mispredict_target_q,
      predicted_flag:    predicted_flag_q,
      except:            except_q,
      bubble:            bubble_q
   };

endmodule

// ==== hdl/dx_branch_resolver.sv ====
/*
 * Branch resolution in decode: taken decision for immediate and
 * register branches, target selection and alignment check, plus
 * the link result and mispredict target handed to execute
 */

module dx_branch_resolver (
   input  dx_pipe_pkg::dx_decode_s  decode_i,
   input  dx_pipe_pkg::dx_execute_s execute_i,
   input  or1k_isa_pkg::word_t     execute_rfb_i,
   input  logic                    predicted_flag_i,
   input  logic                    pipeline_flush_i,
   input  logic                    decode_bubble_i,
   input  logic                    ctrl_interlock_i,
   output logic                    decode_branch_o,
   output or1k_isa_pkg::word_t     decode_branch_target_o,
   output logic                    ibus_align_o,
   output or1k_isa_pkg::word_t     jal_result_o,
   output or1k_isa_pkg::word_t     mispredict_target_o
);

   localparam int ext_width = or1k_isa_pkg::operand_width -
                              or1k_isa_pkg::insn_imm_width - 2;

   logic                branch_to_imm;
   logic                branch_to_reg;
   logic                uncond_jump;
   logic                cond_taken;
   logic                mispredict_imm;
   or1k_isa_pkg::word_t jump_disp;
   or1k_isa_pkg::word_t imm_target;
   or1k_isa_pkg::word_t reg_target;

   // l.j and l.jal have opcode bits 2:1 clear
   assign uncond_jump = ~|decode_i.opc_insn[2:1];

   // l.bf has bit 2 set, l.bnf clear
   assign cond_taken = (decode_i.opc_insn[2] == predicted_flag_i);

   assign branch_to_imm = decode_i.ops.jbr & (uncond_jump | cond_taken);

   // word offset, sign extended and scaled to bytes
   assign jump_disp = {{ext_width{decode_i.imm.jump_off[or1k_isa_pkg::insn_imm_width-1]}},
                       decode_i.imm.jump_off, 2'b00};

   assign imm_target = decode_i.pc + jump_disp;

   assign branch_to_reg = decode_i.ops.jr & ~ctrl_interlock_i;

   // after a bubble the jr source was written by the op now leaving
   // execute, so the decode read is stale
   assign reg_target = (execute_i.bubble | execute_i.ops.jr) ?
                       execute_rfb_i : decode_i.rfb;

   always_comb begin
      if (branch_to_imm) begin
         decode_branch_target_o = imm_target;
      end else begin
         decode_branch_target_o = reg_target;
      end
   end

   assign decode_branch_o = (branch_to_imm | branch_to_reg) &
                            ~pipeline_flush_i & ~decode_bubble_i;

   // target must be word aligned
   assign ibus_align_o = decode_branch_o & (|decode_branch_target_o[1:0]);

   // return address skips the delay slot
   assign jal_result_o = decode_i.pc + or1k_isa_pkg::word_t'(or1k_isa_pkg::delay_slot_step);

   // predicted not taken but could be taken, or the other way round
   assign mispredict_imm = (decode_i.ops.bf & ~predicted_flag_i) |
                           (decode_i.ops.bnf & predicted_flag_i);

   always_comb begin
      if (mispredict_imm) begin
         mispredict_target_o = imm_target;
      end else begin
         mispredict_target_o = jal_result_o;
      end
   end

endmodule

// ==== hdl/dx_hazard_unit.sv ====
/*
 * Decode stage interlock detection: load/mfspr/mul results that
 * bypassing cannot deliver in time, jump-to-register sources still
 * in flight, and rfe stalls; produces the decode bubble
 */

module dx_hazard_unit (
   input  logic                    padv_i,
   input  dx_pipe_pkg::dx_decode_s  decode_i,
   input  dx_pipe_pkg::dx_ctrl_s    ctrl_i,
   input  dx_pipe_pkg::dx_execute_s execute_i,
   output logic                    decode_bubble_o,
   output logic                    ctrl_interlock_o
);

   logic exe_late_op;
   logic exe_hits_src;
   logic ctrl_hits_src;
   logic jr_hazard;

   // control stage result not ready yet for the jr target read
   assign ctrl_interlock_o = (ctrl_i.op_lsu_load | ctrl_i.op_mfspr | ctrl_i.op_mul) &
                             (decode_i.rfb_adr == ctrl_i.rfd_adr);

   // execute ops whose result only shows up in control
   assign exe_late_op = execute_i.ops.lsu_load | execute_i.ops.mfspr |
                        execute_i.ops.mul;

   assign exe_hits_src = exe_late_op &
                         ((decode_i.rfa_adr == execute_i.rfd_adr) |
                          (decode_i.rfb_adr == execute_i.rfd_adr));

   // pipelined multiplier still busy in control
   assign ctrl_hits_src = ctrl_i.op_mul &
                          ((decode_i.rfa_adr == ctrl_i.rfd_adr) |
                           (decode_i.rfb_adr == ctrl_i.rfd_adr));

   // any writer of the jr source in execute holds the jump back
   assign jr_hazard = decode_i.ops.jr &
                      (ctrl_interlock_o | (decode_i.rfb_adr == execute_i.rfd_adr));

   // rfe stalls fetch while it travels up to control
   assign decode_bubble_o = (exe_hits_src | ctrl_hits_src | jr_hazard |
                             decode_i.ops.rfe) & padv_i;

endmodule

// ==== hdl/dx_pipe_pkg.sv ====
/*
 * Pipeline bundles for the decode to execute stage:
 * operation flags, instruction exceptions, the decode input,
 * the control stage state and the registered execute output
 */

package dx_pipe_pkg;

   // one flag per operation class
   typedef struct packed {
      logic alu;
      logic add;
      logic mul;
      logic mul_signed;
      logic shift;
      logic setflag;
      logic jbr;
      logic jr;
      logic jal;
      logic bf;
      logic bnf;
      logic brcond;
      logic branch;
      logic lsu_load;
      logic lsu_store;
      logic mfspr;
      logic mtspr;
      logic rfe;
   } dx_ops_s;

   typedef struct packed {
      logic ibus_err;
      logic illegal;
      logic syscall;
      logic trap;
      // only produced here, from the branch target
      logic ibus_align;
   } dx_except_s;

   typedef struct packed {
      or1k_isa_pkg::word_t     pc;
      dx_ops_s                 ops;
      or1k_isa_pkg::opcode_t   opc_insn;
      or1k_isa_pkg::insn_imm_u imm;
      or1k_isa_pkg::word_t     immediate;
      logic                    immediate_sel;
      or1k_isa_pkg::rf_addr_t  rfd_adr;
      or1k_isa_pkg::rf_addr_t  rfa_adr;
      or1k_isa_pkg::rf_addr_t  rfb_adr;
      logic                    rf_wb;
      // rfb value read from the register file in decode
      or1k_isa_pkg::word_t     rfb;
      dx_except_s              except;
   } dx_decode_s;

   // ops in control that deliver their result late
   typedef struct packed {
      logic                   op_lsu_load;
      logic                   op_mfspr;
      logic                   op_mul;
      or1k_isa_pkg::rf_addr_t rfd_adr;
   } dx_ctrl_s;

   typedef struct packed {
      or1k_isa_pkg::word_t     pc;
      dx_ops_s                 ops;
      or1k_isa_pkg::opcode_t   opc_insn;
      or1k_isa_pkg::insn_imm_u imm;
      or1k_isa_pkg::word_t     immediate;
      logic                    immediate_sel;
      or1k_isa_pkg::rf_addr_t  rfd_adr;
      logic                    rf_wb;
      or1k_isa_pkg::word_t     jal_result;
      or1k_isa_pkg::word_t     mispredict_target;
      logic                    predicted_flag;
      dx_except_s              except;
      logic                    bubble;
   } dx_execute_s;

endpackage

// ==== hdl/or1k_isa_pkg.sv ====
/*
 * OR1K ISA constants shared by the decode/execute stage:
 * operand, register number and opcode widths, the NOP opcode,
 * instruction step sizes and the low 26-bit immediate field union
 */

package or1k_isa_pkg;

   // datapath widths
   localparam int operand_width = 32;
   localparam int rf_addr_width = 5;
   localparam int opcode_width  = 6;

   // split of the low instruction field
   localparam int imm16_width     = 16;
   localparam int imm_upper_width = 10;
   localparam int insn_imm_width  = imm_upper_width + imm16_width;

   // l.nop major opcode placed in execute on a bubble or flush
   localparam logic [opcode_width-1:0] opcode_nop = 6'h05;

   // pc steps in bytes
   localparam int insn_step       = 4;
   // branch plus its delay slot
   localparam int delay_slot_step = 2 * insn_step;

   typedef logic [operand_width-1:0] word_t;
   typedef logic [rf_addr_width-1:0] rf_addr_t;
   typedef logic [opcode_width-1:0]  opcode_t;

   // alu view with the rD/rA fields in its upper bits for most formats
   typedef struct packed {
      logic [imm_upper_width-1:0] upper;
      logic [imm16_width-1:0]     imm16;
   } imm_alu_s;

   // same 26 bits, read as a word offset by jumps and branches
   // or as upper/imm16 by the execute alu
   typedef union packed {
      logic signed [insn_imm_width-1:0] jump_off;
      imm_alu_s                         alu;
   } insn_imm_u;

endpackage
